// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tbReplayQueue
FILELIST ?= src.f
LOG ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flushRangeTracker.sv
// Holds the last recovery flush range and counts how many queue entries
// may still carry ops from it. heldActive doubles as the flushedOpExist level.
`timescale 1ns/1ps

module flushRangeTracker (
    input  logic                  clk,
    input  logic                  rstN,
    input  replayPkg::recoveryT   recovery,
    input  replayPkg::queueCountT count,
    input  logic                  replay,
    output replayPkg::flushRangeT heldRange,
    output logic                  heldActive
);

    // Entries that were queued when the recovery started
    replayPkg::queueCountT suspectCount;

    assign heldActive = (suspectCount != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            suspectCount <= '0;
        end else if (recovery.toRecovery) begin
            suspectCount <= count;
        end else if (heldActive && replay) begin
            suspectCount <= suspectCount - 1'b1;
        end
    end

    // Flush range of the latest recovery
    always_ff @(posedge clk) begin
        if (recovery.toRecovery) begin
            heldRange <= recovery.flushRange;
        end
    end

    // Count must drain within one queue depth of replays
    drainsWithinDepth: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(heldActive) |-> (suspectCount <= replayPkg::queueCountWidth'(replayPkg::queueEntries))
    ) else $error("flush count above queue depth");

endmodule

// File: replayPkg.sv
// Shared widths, bundle types and the flush range test for the replay queue.
// Every other file refers to these by scoped names.
package replayPkg;

    localparam int intLanes = 2;
    localparam int memLanes = 2;
    localparam int queueEntries = 16;
    localparam int queueIndexWidth = 4;
    localparam int queueCountWidth = 5;
    // Pushes that may still arrive once the stall is raised
    localparam int memLatency = 3;
    localparam int almostFullLevel = queueEntries - memLatency;
    localparam int maxInterval = 7;
    localparam int intervalWidth = 3;
    localparam int activeListWidth = 6;
    localparam int mshrCount = 4;
    localparam int mshrPhaseWidth = 3;
    // Load data counts as arrived from this phase on
    localparam int mshrReadyPhase = 4;

    typedef logic [activeListWidth-1:0] activeListPtrT;
    typedef logic [intervalWidth-1:0] intervalT;
    typedef logic [queueCountWidth-1:0] queueCountT;

    typedef struct packed {
        activeListPtrT activeListPtr;
        logic [7:0] opTag;
    } intOpT;

    typedef struct packed {
        activeListPtrT activeListPtr;
        logic isLoad;
        logic hasMshr;
        logic [$clog2(mshrCount)-1:0] mshrId;
        logic [7:0] opTag;
    } memOpT;

    typedef struct packed {
        logic [intLanes-1:0] intValid;
        intOpT [intLanes-1:0] intOp;
        logic [memLanes-1:0] memValid;
        memOpT [memLanes-1:0] memOp;
    } replayBundleT;

    typedef struct packed {
        replayBundleT bundle;
        // Cycles to wait after the previous entry left
        intervalT replayInterval;
    } queueEntryT;

    typedef struct packed {
        logic [mshrCount-1:0] valid;
        logic [mshrCount-1:0][mshrPhaseWidth-1:0] phase;
    } mshrStateT;

    typedef struct packed {
        activeListPtrT headPtr;
        activeListPtrT tailPtr;
        logic flushAll;
    } flushRangeT;

    typedef struct packed {
        logic toRecovery;
        flushRangeT flushRange;
    } recoveryT;

    // Range is [headPtr, tailPtr) and may wrap past the end of the active list
    function automatic logic inFlushRange(activeListPtrT ptr, flushRangeT flushRange);
        if (flushRange.flushAll) begin
            return 1'b1;
        end
        if (flushRange.headPtr <= flushRange.tailPtr) begin
            return (ptr >= flushRange.headPtr) && (ptr < flushRange.tailPtr);
        end
        return (ptr >= flushRange.headPtr) || (ptr < flushRange.tailPtr);
    endfunction

endpackage

// File: replayQueue.sv
// Top level of the replay queue: recorder, store, flush tracker and scheduler.
// Bundles recorded at issue come back on replayBundle in order, with their spacing.
`timescale 1ns/1ps

module replayQueue (
    input  logic                    clk,
    input  logic                    rstN,
    input  replayPkg::replayBundleT recordBundle,
    input  replayPkg::mshrStateT    mshrState,
    input  replayPkg::recoveryT     recovery,
    output replayPkg::replayBundleT replayBundle,
    output logic                    replay,
    output logic                    stallUpper,
    output logic                    flushedOpExist
);

    logic pushEntry;
    logic popEntry;
    logic full;
    logic empty;
    logic almostFull;
    logic noValidBundle;
    replayPkg::queueEntryT pushData;
    replayPkg::queueEntryT headEntry;
    replayPkg::queueCountT count;
    replayPkg::flushRangeT heldRange;

    replayRecorder i_replayRecorder (
        .clk           (clk),
        .rstN          (rstN),
        .recordBundle  (recordBundle),
        .full          (full),
        .noValidBundle (noValidBundle),
        .pushEntry     (pushEntry),
        .pushData      (pushData)
    );

    replayStore i_replayStore (
        .clk           (clk),
        .rstN          (rstN),
        .pushEntry     (pushEntry),
        .pushData      (pushData),
        .popEntry      (popEntry),
        .headEntry     (headEntry),
        .full          (full),
        .empty         (empty),
        .noValidBundle (noValidBundle),
        .almostFull    (almostFull),
        .count         (count)
    );

    // heldActive is the flushedOpExist level seen outside
    flushRangeTracker i_flushRangeTracker (
        .clk        (clk),
        .rstN       (rstN),
        .recovery   (recovery),
        .count      (count),
        .replay     (replay),
        .heldRange  (heldRange),
        .heldActive (flushedOpExist)
    );

    replayScheduler i_replayScheduler (
        .clk          (clk),
        .rstN         (rstN),
        .headEntry    (headEntry),
        .empty        (empty),
        .mshrState    (mshrState),
        .recovery     (recovery),
        .heldRange    (heldRange),
        .heldActive   (flushedOpExist),
        .almostFull   (almostFull),
        .popEntry     (popEntry),
        .replay       (replay),
        .stallUpper   (stallUpper),
        .replayBundle (replayBundle)
    );

endmodule

// File: replayRecorder.sv
// Input side of the replay queue. Stamps each issued bundle with the number
// of cycles since the previous push and decides whether it enters the store.
// Empty bubbles are pushed while valid bundles remain, so gaps survive replay.
`timescale 1ns/1ps

module replayRecorder (
    input  logic                    clk,
    input  logic                    rstN,
    input  replayPkg::replayBundleT recordBundle,
    input  logic                    full,
    input  logic                    noValidBundle,
    output logic                    pushEntry,
    output replayPkg::queueEntryT   pushData
);

    replayPkg::intervalT intervalIn;
    logic recordValid;

    assign recordValid = (|recordBundle.intValid) || (|recordBundle.memValid);

    // Bubble push keeps spacing only while something valid is still queued
    always_comb begin
        pushEntry = !full && (recordValid || !noValidBundle);
        pushData.bundle = recordBundle;
        pushData.replayInterval = intervalIn;
    end

    // Saturating distance from the last push
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            intervalIn <= '0;
        end else if (pushEntry) begin
            intervalIn <= '0;
        end else if (intervalIn < replayPkg::intervalWidth'(replayPkg::maxInterval)) begin
            intervalIn <= intervalIn + 1'b1;
        end
    end

    // A record while the store is full would be lost
    noPushWhenFull: assert property (
        @(posedge clk) disable iff (!rstN)
        recordValid |-> !full
    ) else $error("record while store full");

endmodule

// File: replayScheduler.sv
// Output side of the replay queue. Pops the head once its interval has
// elapsed and no load in it waits on an MSHR, drops flushed ops and
// registers the bundle for the issue stage. Also drives the upper stall.
`timescale 1ns/1ps

module replayScheduler (
    input  logic                    clk,
    input  logic                    rstN,
    input  replayPkg::queueEntryT   headEntry,
    input  logic                    empty,
    input  replayPkg::mshrStateT    mshrState,
    input  replayPkg::recoveryT     recovery,
    input  replayPkg::flushRangeT   heldRange,
    input  logic                    heldActive,
    input  logic                    almostFull,
    output logic                    popEntry,
    output logic                    replay,
    output logic                    stallUpper,
    output replayPkg::replayBundleT replayBundle
);

    replayPkg::intervalT intervalCount;
    logic [replayPkg::intLanes-1:0] flushInt;
    logic [replayPkg::memLanes-1:0] flushMem;
    logic [replayPkg::memLanes-1:0] loadWaiting;
    logic headValid;

    // Valid bits and ops are registered apart
    logic [replayPkg::intLanes-1:0] intValidReg;
    logic [replayPkg::memLanes-1:0] memValidReg;
    replayPkg::intOpT [replayPkg::intLanes-1:0] intOpReg;
    replayPkg::memOpT [replayPkg::memLanes-1:0] memOpReg;

    // The just-arrived range is checked too, since the held copy lags a cycle
    always_comb begin
        for (int i = 0; i < replayPkg::intLanes; i++) begin
            flushInt[i] =
                (heldActive &&
                 replayPkg::inFlushRange(headEntry.bundle.intOp[i].activeListPtr, heldRange)) ||
                (recovery.toRecovery &&
                 replayPkg::inFlushRange(headEntry.bundle.intOp[i].activeListPtr,
                                         recovery.flushRange));
        end
        for (int i = 0; i < replayPkg::memLanes; i++) begin
            flushMem[i] =
                (heldActive &&
                 replayPkg::inFlushRange(headEntry.bundle.memOp[i].activeListPtr, heldRange)) ||
                (recovery.toRecovery &&
                 replayPkg::inFlushRange(headEntry.bundle.memOp[i].activeListPtr,
                                         recovery.flushRange));
        end
    end

    // A flushed load is let through since its MSHR may never become ready
    always_comb begin
        for (int i = 0; i < replayPkg::memLanes; i++) begin
            loadWaiting[i] =
                headEntry.bundle.memValid[i] && !flushMem[i] &&
                headEntry.bundle.memOp[i].isLoad &&
                headEntry.bundle.memOp[i].hasMshr &&
                mshrState.valid[headEntry.bundle.memOp[i].mshrId] &&
                (mshrState.phase[headEntry.bundle.memOp[i].mshrId] <
                 replayPkg::mshrPhaseWidth'(replayPkg::mshrReadyPhase));
        end
        headValid = (|headEntry.bundle.intValid) || (|headEntry.bundle.memValid);
        popEntry = !empty && (intervalCount >= headEntry.replayInterval) &&
                   (loadWaiting == '0);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            intervalCount <= '0;
            intValidReg <= '0;
            memValidReg <= '0;
            replay <= 1'b0;
        end else begin
            if (popEntry) begin
                intervalCount <= '0;
            end else if (intervalCount < replayPkg::intervalWidth'(replayPkg::maxInterval)) begin
                intervalCount <= intervalCount + 1'b1;
            end
            intValidReg <= popEntry ? (headEntry.bundle.intValid & ~flushInt) : '0;
            memValidReg <= popEntry ? (headEntry.bundle.memValid & ~flushMem) : '0;
            replay <= popEntry && headValid;
        end
    end

    always_ff @(posedge clk) begin
        intOpReg <= headEntry.bundle.intOp;
        memOpReg <= headEntry.bundle.memOp;
    end

    always_comb begin
        replayBundle.intValid = intValidReg;
        replayBundle.intOp = intOpReg;
        replayBundle.memValid = memValidReg;
        replayBundle.memOp = memOpReg;
        stallUpper = replay || almostFull;
    end

    noValidWithoutReplay: assert property (
        @(posedge clk) disable iff (!rstN)
        !replay |-> (intValidReg == '0) && (memValidReg == '0)
    ) else $error("replayBundle valid while replay low");

endmodule

// File: replayStimulus.txt
// kind and hex fields: rec n intValid memValid ptrBase tagBase loadMask mshrId
// exp n intValid memValid tagBase minGap / mshr valid phases / rcv head tail flushAll
// lvl stallUpper flushedOpExist / idle n / drain; ptr and tag step by 4 per bundle
exp 1 3 0 10 0
exp 1 1 1 20 1
exp 1 0 3 30 4
exp 1 3 3 40 7
idle 8
lvl 0 0
rec 1 3 0 01 10 0 0
rec 1 1 1 05 20 0 0
idle 3
rec 1 0 3 09 30 0 0
idle a
rec 1 3 3 0d 40 0 0
drain
// Load on MSHR 0 holds the head, then a flush of active-list range 10 to 1a
exp 1 0 1 50 5
exp 3 3 3 60 1
exp 2 0 0 6c 1
exp 1 0 3 74 1
exp 6 3 3 78 1
mshr 1 001
rec 1 0 1 00 50 1 0
rec c 3 3 04 60 0 0
rcv 10 1a 0
lvl 1 1
mshr 1 004
drain
idle 4
lvl 0 0

// File: replayStore.sv
// Circular buffer holding recorded entries in order.
// Tracks occupancy and how many stored bundles carry a valid op;
// the head entry is read combinationally by the scheduler.
`timescale 1ns/1ps

module replayStore (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  pushEntry,
    input  replayPkg::queueEntryT pushData,
    input  logic                  popEntry,
    output replayPkg::queueEntryT headEntry,
    output logic                  full,
    output logic                  empty,
    output logic                  noValidBundle,
    output logic                  almostFull,
    output replayPkg::queueCountT count
);

    replayPkg::queueEntryT entries [replayPkg::queueEntries];

    logic [replayPkg::queueIndexWidth-1:0] headPtr;
    logic [replayPkg::queueIndexWidth-1:0] tailPtr;
    replayPkg::queueCountT validCount;
    replayPkg::queueCountT validCountNext;
    logic pushValid;
    logic popValid;

    assign headEntry = entries[headPtr];

    always_comb begin
        full = (count == replayPkg::queueCountWidth'(replayPkg::queueEntries));
        empty = (count == '0);
        almostFull = (count >= replayPkg::queueCountWidth'(replayPkg::almostFullLevel));
        noValidBundle = (validCount == '0);

        pushValid = (|pushData.bundle.intValid) || (|pushData.bundle.memValid);
        popValid = (|headEntry.bundle.intValid) || (|headEntry.bundle.memValid);

        validCountNext = validCount;
        if (pushEntry && pushValid) begin
            validCountNext = validCountNext + 1'b1;
        end
        if (popEntry && popValid) begin
            validCountNext = validCountNext - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pushEntry) begin
            entries[tailPtr] <= pushData;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            validCount <= '0;
        end else begin
            if (pushEntry) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (popEntry) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({pushEntry, popEntry})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            validCount <= validCountNext;
        end
    end

    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (!rstN) popEntry |-> !empty
    ) else $error("pop from empty store");

    noPushWhenFull: assert property (
        @(posedge clk) disable iff (!rstN) pushEntry |-> !full
    ) else $error("push into full store");

endmodule

// File: src.f
replayPkg.sv
replayRecorder.sv
replayStore.sv
flushRangeTracker.sv
replayScheduler.sv
replayQueue.sv
tbReplayQueue.sv

// File: tbReplayQueue.sv
// Testbench for the replay queue. Stimulus lines come from replayStimulus.txt;
// expected replays are queued in order and checked as replay pulses arrive.
// Run through the Makefile, which looks for the pass line in the log.
`timescale 1ns/1ps

module tbReplayQueue;

    logic clk;
    logic rstN;
    replayPkg::replayBundleT recordBundle;
    replayPkg::mshrStateT mshrState;
    replayPkg::recoveryT recovery;
    replayPkg::replayBundleT replayBundle;
    logic replay;
    logic stallUpper;
    logic flushedOpExist;

    string lines[$];
    int lineCount = 0;
    replayPkg::replayBundleT expBundles[$];
    int expGaps[$];
    int gapCount = 0;

    replayQueue i_replayQueue (
        .clk            (clk),
        .rstN           (rstN),
        .recordBundle   (recordBundle),
        .mshrState      (mshrState),
        .recovery       (recovery),
        .replayBundle   (replayBundle),
        .replay         (replay),
        .stallUpper     (stallUpper),
        .flushedOpExist (flushedOpExist)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkLevel(string name, logic got, logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkTag(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            stopOnError($sformatf("Fail %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Valid bits must match; tags only count on lanes that are valid
    task automatic checkBundle(replayPkg::replayBundleT got, replayPkg::replayBundleT exp);
        if (got.intValid !== exp.intValid) begin
            stopOnError($sformatf("Fail replayBundle.intValid: got %h expected %h",
                                  got.intValid, exp.intValid));
        end
        if (got.memValid !== exp.memValid) begin
            stopOnError($sformatf("Fail replayBundle.memValid: got %h expected %h",
                                  got.memValid, exp.memValid));
        end
        for (int i = 0; i < replayPkg::intLanes; i++) begin
            if (exp.intValid[i]) begin
                checkTag($sformatf("replayBundle.intOp[%0d].opTag", i),
                         got.intOp[i].opTag, exp.intOp[i].opTag);
            end
        end
        for (int i = 0; i < replayPkg::memLanes; i++) begin
            if (exp.memValid[i]) begin
                checkTag($sformatf("replayBundle.memOp[%0d].opTag", i),
                         got.memOp[i].opTag, exp.memOp[i].opTag);
            end
        end
    endtask

    // Int lanes take ptrBase and tagBase upward, mem lanes follow them
    function automatic replayPkg::replayBundleT makeBundle(int intValid, int memValid,
            int ptrBase, int tagBase, int loadMask, int mshrId);
        replayPkg::replayBundleT b;
        b = '0;
        b.intValid = 2'(intValid);
        b.memValid = 2'(memValid);
        for (int i = 0; i < replayPkg::intLanes; i++) begin
            b.intOp[i].activeListPtr = replayPkg::activeListPtrT'(ptrBase + i);
            b.intOp[i].opTag = 8'(tagBase + i);
        end
        for (int i = 0; i < replayPkg::memLanes; i++) begin
            b.memOp[i].activeListPtr =
                replayPkg::activeListPtrT'(ptrBase + replayPkg::intLanes + i);
            b.memOp[i].isLoad = loadMask[i];
            b.memOp[i].hasMshr = loadMask[i];
            b.memOp[i].mshrId = 2'(mshrId);
            b.memOp[i].opTag = 8'(tagBase + replayPkg::intLanes + i);
        end
        return b;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
        recordBundle = '0;
        recovery = '0;
    endtask

    task automatic runLine(string line);
        string kind;
        int f[7];
        f = '{default: 0};
        void'($sscanf(line, "%s %h %h %h %h %h %h %h",
                      kind, f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
        case (kind)
            "idle": repeat (f[0]) nextCycle();
            "rec": begin
                for (int k = 0; k < f[0]; k++) begin
                    nextCycle();
                    recordBundle = makeBundle(f[1], f[2], f[3] + 4 * k, f[4] + 4 * k, f[5], f[6]);
                end
            end
            "exp": begin
                for (int k = 0; k < f[0]; k++) begin
                    expBundles.push_back(makeBundle(f[1], f[2], 0, f[3] + 4 * k, 0, 0));
                    expGaps.push_back((k == 0) ? f[4] : 1);
                end
            end
            "mshr": begin
                nextCycle();
                mshrState = {4'(f[0]), 12'(f[1])};
            end
            "rcv": begin
                nextCycle();
                recovery = {1'b1, 6'(f[0]), 6'(f[1]), 1'(f[2])};
            end
            "lvl": begin
                nextCycle();
                @(negedge clk);
                checkLevel("stallUpper", stallUpper, 1'(f[0]));
                checkLevel("flushedOpExist", flushedOpExist, 1'(f[1]));
            end
            "drain": while (expBundles.size() != 0) nextCycle();
            default: stopOnError($sformatf("Unknown stimulus line: %s", line));
        endcase
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        fd = $fopen("replayStimulus.txt", "r");
        if (fd == 0) begin
            stopOnError("Could not open the stimulus file replayStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 1) != "//") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rstN = 1'b0;
        recordBundle = '0;
        mshrState = '0;
        recovery = '0;
        loadStimulus();
        lineCount = lines.size();
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        foreach (lines[i]) begin
            runLine(lines[i]);
        end
        if (expBundles.size() != 0) begin
            stopOnError("Some expected replays never arrived");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // Outputs only move at the rising edge, so the falling edge is a safe sample point
    initial begin
        replayPkg::replayBundleT want;
        int minGap;
        wait (rstN === 1'b1);
        forever begin
            @(negedge clk);
            gapCount++;
            if (replay) begin
                checkLevel("stallUpper", stallUpper, 1'b1);
                if (expBundles.size() == 0) begin
                    stopOnError("A bundle was replayed when none was expected");
                end else begin
                    want = expBundles.pop_front();
                    minGap = expGaps.pop_front();
                    if (gapCount < minGap) begin
                        stopOnError($sformatf("Fail replay gap: got %h expected at least %h",
                                              gapCount, minGap));
                    end
                    checkBundle(replayBundle, want);
                    gapCount = 0;
                end
            end else begin
                checkLevel("replayBundle valid",
                           (|replayBundle.intValid) || (|replayBundle.memValid), 1'b0);
            end
        end
    end

    // Generous bound of 40 cycles per stimulus line
    initial begin
        wait (lineCount > 0);
        repeat (lineCount * 40) @(posedge clk);
        stopOnError("Timeout: the run did not finish within the expected number of cycles");
    end

endmodule
